// ==== src/mmuPkg.sv ====
package mmuPkg;

  // Section translation uses the top 12 address bits as the tag
  localparam int SectionTagBits = 12;

  // TLB depth when the top level does not override it
  localparam int DefaultTlbSize = 8;

  // Descriptor field positions
  localparam int DescTypeMsb   = 1;
  localparam int DescTypeLsb   = 0;
  localparam int DescDomainMsb = 8;
  localparam int DescDomainLsb = 5;
  localparam int DescApMsb     = 11;
  localparam int DescApLsb     = 10;
  localparam int DescBaseMsb   = 31;
  localparam int DescBaseLsb   = 20;

  // Type field of a valid section descriptor
  localparam logic [1:0] DescTypeSection = 2'b10;

  // Fault status codes, low nibble of the fault status register
  typedef enum logic [3:0] {
    noFault                 = 4'b0000,
    alignFault              = 4'b0001,
    sectionTranslationFault = 4'b0101,
    sectionDomainFault      = 4'b1001,
    sectionPermissionFault  = 4'b1101
  } faultCode;

  // AP bits of a section descriptor
  typedef enum logic [1:0] {
    apNone     = 2'b00,
    apSupOnly  = 2'b01,
    apUserRead = 2'b10,
    apFull     = 2'b11
  } accessPerm;

  // Two bits per domain in the domain access register
  typedef enum logic [1:0] {
    noAccess = 2'b00,
    client   = 2'b01,
    reserved = 2'b10,
    manager  = 2'b11
  } domainMode;

  // One cached section translation
  typedef struct packed {
    logic [SectionTagBits-1:0] virtTag;
    logic [SectionTagBits-1:0] physBase;
    logic [3:0]                domain;
    accessPerm                 ap;
  } tlbEntry;

endpackage

// ==== src/memBusIf.sv ====
`timescale 1ns/100ps

// One requester port of the shared memory bus
interface memBusIf;

  logic [31:0] addr;
  logic [31:0] wdata;
  // Read data, valid in the cycle that ready is high
  logic [31:0] rdata;
  // Level request, held with its signals until ready
  logic        req;
  logic        write;
  // Transfer completes in a cycle with ready high
  logic        ready;

  // Walker or CPU access side
  modport requester (
    output addr, wdata, req, write,
    input  rdata, ready
  );

  // Arbiter side
  modport arbiter (
    input  addr, wdata, req, write,
    output rdata, ready
  );

endinterface

// ==== src/tlb.sv ====
`timescale 1ns/100ps

module tlb import mmuPkg::*; #(
  parameter int TlbSize = DefaultTlbSize
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      enable,
  input  logic                      cpuReq,
  input  logic                      flush,
  input  logic                      refill,
  input  logic [SectionTagBits-1:0] virtTag,
  input  tlbEntry                   refillEntry,
  output logic                      hit,
  output logic                      miss,
  output tlbEntry                   hitEntry
);

  localparam int PtrBits = $clog2(TlbSize);

  // Entry storage, only the valid bits are reset
  tlbEntry                entries [TlbSize];
  logic [TlbSize-1:0]     valid;
  logic [TlbSize-1:0]     match;
  logic [PtrBits-1:0]     fillPtr;
  logic                   anyMatch;
  logic                   lookup;

  // A lookup only counts while translating a CPU request
  assign lookup = cpuReq & enable;

  // Parallel tag compare against every valid entry
  always_comb begin
    for (int i = 0; i < TlbSize; i++) begin
      match[i] = valid[i] & (entries[i].virtTag == virtTag);
    end
  end

  assign anyMatch = |match;
  assign hit      = lookup & anyMatch;
  assign miss     = lookup & ~anyMatch;

  // Tags are unique, so at most one entry matches
  always_comb begin
    hitEntry = '0;
    for (int i = 0; i < TlbSize; i++) begin
      if (match[i]) begin
        hitEntry = entries[i];
      end
    end
  end

  // Valid bits and round-robin victim pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      valid   <= '0;
      fillPtr <= '0;
    end else if (flush) begin
      // Flush wins over a refill in the same cycle
      valid <= '0;
    end else if (refill) begin
      valid[fillPtr] <= 1'b1;
      if (fillPtr == PtrBits'(TlbSize - 1)) begin
        fillPtr <= '0;
      end else begin
        fillPtr <= fillPtr + 1'b1;
      end
    end
  end

  // Entry payload written at the victim slot
  always_ff @(posedge clk) begin
    if (refill) begin
      entries[fillPtr] <= refillEntry;
    end
  end

endmodule

// ==== src/tableWalker.sv ====
`timescale 1ns/100ps

module tableWalker import mmuPkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      miss,
  input  logic [SectionTagBits-1:0] virtTag,
  input  logic [17:0]               tableBase,
  memBusIf.requester                walkBus,
  output logic                      refill,
  output logic                      walkFault,
  output tlbEntry                   refillEntry
);

  typedef enum logic {
    idle  = 1'b0,
    fetch = 1'b1
  } walkState;

  walkState                  state;
  // Tag of the section being walked
  logic [SectionTagBits-1:0] tagQ;
  logic [31:0]               desc;
  logic                      done;
  logic                      isSection;
  logic                      sameAccess;

  // Walk FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (miss) begin
            state <= fetch;
          end
        end
        fetch: begin
          // Request held until the bus answers
          if (walkBus.ready) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Tag capture on the miss
  always_ff @(posedge clk) begin
    if (state == idle && miss) begin
      tagQ <= virtTag;
    end
  end

  // Descriptor address is the table base indexed by the tag, word aligned
  assign walkBus.addr  = {tableBase, tagQ, 2'b00};
  assign walkBus.wdata = '0;
  assign walkBus.write = 1'b0;
  assign walkBus.req   = (state == fetch);

  assign desc      = walkBus.rdata;
  assign done      = (state == fetch) & walkBus.ready;
  assign isSection = (desc[DescTypeMsb:DescTypeLsb] == DescTypeSection);

  // The CPU may have moved on after an earlier abort
  assign sameAccess = miss & (virtTag == tagQ);

  // Decode the fetched descriptor
  assign refill    = done & isSection;
  assign walkFault = done & ~isSection & sameAccess;

  always_comb begin
    refillEntry.virtTag  = tagQ;
    refillEntry.physBase = desc[DescBaseMsb:DescBaseLsb];
    refillEntry.domain   = desc[DescDomainMsb:DescDomainLsb];
    refillEntry.ap       = accessPerm'(desc[DescApMsb:DescApLsb]);
  end

endmodule

// ==== src/accessCheck.sv ====
`timescale 1ns/100ps

module accessCheck import mmuPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        enable,
  input  logic        alignCheck,
  input  logic        cpuReq,
  input  logic        cpuWrite,
  input  logic        wordAccess,
  input  logic        supMode,
  input  logic        dataAccess,
  input  logic        hit,
  input  logic        walkFault,
  input  logic [31:0] cpuAddr,
  input  logic [31:0] cpuWData,
  input  logic [31:0] dacr,
  input  tlbEntry     hitEntry,
  memBusIf.requester  cpuBus,
  output logic [31:0] cpuRData,
  output logic        cpuReady,
  output logic        dataAbort,
  output logic        prefetchAbort,
  output logic [7:0]  faultStatus,
  output logic [31:0] faultAddr
);

  faultCode    code;
  domainMode   domMode;
  logic [3:0]  faultDomain;
  logic        alignErr;
  logic        permErr;
  logic        faultNow;
  logic        accessOk;
  logic [7:0]  statusQ;
  logic [31:0] addrQ;

  // Two DACR bits per domain
  assign domMode  = domainMode'(dacr[{hitEntry.domain, 1'b0} +: 2]);
  assign alignErr = alignCheck & wordAccess & (cpuAddr[1:0] != 2'b00);

  // Client domains obey the AP bits
  always_comb begin
    case (hitEntry.ap)
      apNone:     permErr = 1'b1;
      apSupOnly:  permErr = ~supMode;
      apUserRead: permErr = ~supMode & cpuWrite;
      default:    permErr = 1'b0;
    endcase
  end

  // Fault priority, alignment first even ahead of a miss
  always_comb begin
    code        = noFault;
    faultDomain = 4'd0;
    if (alignErr) begin
      code = alignFault;
    end else if (walkFault) begin
      code = sectionTranslationFault;
    end else if (hit) begin
      faultDomain = hitEntry.domain;
      if (domMode == noAccess || domMode == reserved) begin
        code = sectionDomainFault;
      end else if (domMode == client && permErr) begin
        code = sectionPermissionFault;
      end
    end
  end

  assign faultNow = cpuReq & enable & (code != noFault);
  assign accessOk = cpuReq & hit & (code == noFault);

  // Bypass passes the CPU access straight through
  assign cpuBus.req   = enable ? accessOk : cpuReq;
  assign cpuBus.addr  = enable ? {hitEntry.physBase, cpuAddr[19:0]} : cpuAddr;
  assign cpuBus.write = cpuWrite;
  assign cpuBus.wdata = cpuWData;
  assign cpuRData     = cpuBus.rdata;

  // A fault completes the access without a bus transfer
  assign cpuReady      = faultNow | (cpuBus.req & cpuBus.ready);
  assign dataAbort     = faultNow & dataAccess;
  assign prefetchAbort = faultNow & ~dataAccess;

  // New status shows in the abort cycle, registers hold it afterwards
  assign faultStatus = faultNow ? {faultDomain, code} : statusQ;
  assign faultAddr   = faultNow ? cpuAddr : addrQ;

  always_ff @(posedge clk) begin
    if (rst) begin
      statusQ <= {4'd0, noFault};
    end else if (faultNow) begin
      statusQ <= {faultDomain, code};
    end
  end

  always_ff @(posedge clk) begin
    if (faultNow) begin
      addrQ <= cpuAddr;
    end
  end

endmodule

// ==== src/busArbiter.sv ====
`timescale 1ns/100ps

module busArbiter (
  input  logic        clk,
  input  logic        rst,
  memBusIf.arbiter    walkBus,
  memBusIf.arbiter    cpuBus,
  input  logic [31:0] memRData,
  input  logic        memReady,
  output logic [31:0] memAddr,
  output logic [31:0] memWData,
  output logic        memReq,
  output logic        memWrite
);

  // Transfer open and its owner
  logic busy;
  logic ownerWalk;
  logic selWalk;

  // Walker at fixed priority when the bus is free
  assign selWalk = busy ? ownerWalk : walkBus.req;

  // Grant is locked from request until ready
  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      ownerWalk <= 1'b0;
    end else if (memReq && !memReady) begin
      busy      <= 1'b1;
      ownerWalk <= selWalk;
    end else if (memReady) begin
      busy <= 1'b0;
    end
  end

  // Granted side drives the bus
  always_comb begin
    if (selWalk) begin
      memAddr  = walkBus.addr;
      memWData = walkBus.wdata;
      memReq   = walkBus.req;
      memWrite = walkBus.write;
    end else begin
      memAddr  = cpuBus.addr;
      memWData = cpuBus.wdata;
      memReq   = cpuBus.req;
      memWrite = cpuBus.write;
    end
  end

  // Response only to the granted side
  assign walkBus.ready = selWalk & memReady;
  assign cpuBus.ready  = ~selWalk & memReady;
  assign walkBus.rdata = selWalk ? memRData : '0;
  assign cpuBus.rdata  = selWalk ? '0 : memRData;

endmodule

// ==== src/mmu.sv ====
`timescale 1ns/100ps

module mmu import mmuPkg::*; #(
  parameter int TlbSize = DefaultTlbSize
) (
  input  logic        clk,
  input  logic        rst,
  // Bit 0 enables translation, bit 1 the alignment check
  input  logic [31:0] control,
  input  logic [17:0] tableBase,
  input  logic [31:0] dacr,
  input  logic        tlbFlush,
  // CPU side
  input  logic        cpuReq,
  input  logic        cpuWrite,
  input  logic        wordAccess,
  input  logic        supMode,
  input  logic        dataAccess,
  input  logic [31:0] cpuAddr,
  input  logic [31:0] cpuWData,
  output logic [31:0] cpuRData,
  output logic        cpuReady,
  output logic        dataAbort,
  output logic        prefetchAbort,
  output logic [7:0]  faultStatus,
  output logic [31:0] faultAddr,
  // Shared memory bus
  output logic [31:0] memAddr,
  output logic [31:0] memWData,
  output logic        memReq,
  output logic        memWrite,
  input  logic [31:0] memRData,
  input  logic        memReady
);

  logic    enable;
  logic    alignCheck;
  logic    hit;
  logic    miss;
  logic    refill;
  logic    walkFault;
  tlbEntry hitEntry;
  tlbEntry refillEntry;

  memBusIf walkBus ();
  memBusIf cpuBus ();

  assign enable     = control[0];
  assign alignCheck = control[1];

  tlb #(.TlbSize(TlbSize)) tlbInst (
    .clk(clk), .rst(rst), .enable(enable), .cpuReq(cpuReq), .flush(tlbFlush),
    .refill(refill), .virtTag(cpuAddr[31:32-SectionTagBits]),
    .refillEntry(refillEntry), .hit(hit), .miss(miss), .hitEntry(hitEntry)
  );

  tableWalker walker (
    .clk(clk), .rst(rst), .miss(miss), .virtTag(cpuAddr[31:32-SectionTagBits]),
    .tableBase(tableBase), .walkBus(walkBus.requester), .refill(refill),
    .walkFault(walkFault), .refillEntry(refillEntry)
  );

  accessCheck check (
    .clk(clk), .rst(rst), .enable(enable), .alignCheck(alignCheck), .cpuReq(cpuReq),
    .cpuWrite(cpuWrite), .wordAccess(wordAccess), .supMode(supMode),
    .dataAccess(dataAccess), .hit(hit), .walkFault(walkFault), .cpuAddr(cpuAddr),
    .cpuWData(cpuWData), .dacr(dacr), .hitEntry(hitEntry), .cpuBus(cpuBus.requester),
    .cpuRData(cpuRData), .cpuReady(cpuReady), .dataAbort(dataAbort),
    .prefetchAbort(prefetchAbort), .faultStatus(faultStatus), .faultAddr(faultAddr)
  );

  // Walker outranks the CPU on the shared bus
  busArbiter arbiter (
    .clk(clk), .rst(rst), .walkBus(walkBus.arbiter), .cpuBus(cpuBus.arbiter),
    .memRData(memRData), .memReady(memReady), .memAddr(memAddr),
    .memWData(memWData), .memReq(memReq), .memWrite(memWrite)
  );

endmodule

// ==== verif/mmuTbMem.sv ====
`timescale 1ns/100ps

// Memory model for the shared bus, page table plus data words
module mmuTbMem #(
  parameter logic [31:0] Pattern = 32'h5A3C_96E1
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [17:0] tableBase,
  input  logic [31:0] memAddr,
  input  logic [31:0] memWData,
  input  logic        memReq,
  input  logic        memWrite,
  output logic [31:0] memRData,
  output logic        memReady,
  output int          descReads,
  output int          dataAccesses,
  output logic [31:0] lastDataAddr
);

  // One descriptor per section tag
  logic [31:0] pageTable [4096];
  // Small store for written words, tagged by full address
  logic [31:0] wordAddr [256];
  logic [31:0] wordData [256];
  logic        wordValid [256];
  logic        pending;
  int          waitCnt;
  integer      seed;
  logic        inTable;
  logic [7:0]  slot;

  initial begin
    seed = 55;
    for (int i = 0; i < 4096; i++) begin
      pageTable[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      wordValid[i] = 1'b0;
    end
  end

  task automatic setDesc(input logic [11:0] tag, input logic [31:0] value);
    pageTable[tag] = value;
  endtask

  // Table occupies the 16 KB window at the table base
  assign inTable = (memAddr[31:14] == tableBase);
  assign slot    = memAddr[9:2];

  always @(posedge clk) begin
    if (rst) begin
      memReady     <= 1'b0;
      pending      <= 1'b0;
      descReads    <= 0;
      dataAccesses <= 0;
    end else if (memReady) begin
      memReady <= 1'b0;
      pending  <= 1'b0;
    end else if (memReq && !pending) begin
      // Random wait of 0 to 3 cycles per transfer
      pending <= 1'b1;
      waitCnt <= {$random(seed)} % 4;
    end else if (memReq && waitCnt > 0) begin
      waitCnt <= waitCnt - 1;
    end else if (memReq) begin
      memReady <= 1'b1;
      if (inTable) begin
        memRData  <= pageTable[memAddr[13:2]];
        descReads <= descReads + 1;
      end else begin
        dataAccesses <= dataAccesses + 1;
        lastDataAddr <= memAddr;
        if (memWrite) begin
          wordAddr[slot]  <= memAddr;
          wordData[slot]  <= memWData;
          wordValid[slot] <= 1'b1;
        end else if (wordValid[slot] && wordAddr[slot] == memAddr) begin
          memRData <= wordData[slot];
        end else begin
          // Unwritten words follow the address pattern
          memRData <= memAddr ^ Pattern;
        end
      end
    end
  end

endmodule

// ==== verif/mmuTb.sv ====
`timescale 1ns/100ps

module mmuTb import mmuPkg::*; ();

  localparam int          TlbSize     = 8;
  localparam logic [31:0] DataPattern = 32'h5A3C_96E1;
  // Page table window at 0xC000_0000 above every data section used
  localparam logic [17:0] TableBase   = 18'h3_0000;
  // Domains 0 and 3 client with 1 noAccess and 2 manager
  localparam logic [31:0] Dacr        = 32'h0000_0071;
  // Walk plus data transfer with the longest memory waits fits in 20 cycles
  localparam int NumAccesses    = 32;
  localparam int AccessCycles   = 20;
  localparam int WatchdogCycles = NumAccesses * AccessCycles + 50;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] control, dacr, cpuAddr, cpuWData, cpuRData, faultAddr;
  logic [17:0] tableBase;
  logic        tlbFlush, cpuReq, cpuWrite, wordAccess, supMode, dataAccess;
  logic        cpuReady, dataAbort, prefetchAbort;
  logic [7:0]  faultStatus;
  logic [31:0] memAddr, memWData, memRData;
  logic        memReq, memWrite, memReady;
  // Outputs captured in the completion cycle
  logic [31:0] gotRData, gotFaultAddr;
  logic [7:0]  gotStatus;
  logic        gotDAbort, gotPAbort;
  integer      seed = 55;

  mmu #(.TlbSize(TlbSize)) UUT (
    .clk(clk), .rst(rst), .control(control), .tableBase(tableBase), .dacr(dacr),
    .tlbFlush(tlbFlush), .cpuReq(cpuReq), .cpuWrite(cpuWrite), .wordAccess(wordAccess),
    .supMode(supMode), .dataAccess(dataAccess), .cpuAddr(cpuAddr), .cpuWData(cpuWData),
    .cpuRData(cpuRData), .cpuReady(cpuReady), .dataAbort(dataAbort),
    .prefetchAbort(prefetchAbort), .faultStatus(faultStatus), .faultAddr(faultAddr),
    .memAddr(memAddr), .memWData(memWData), .memReq(memReq), .memWrite(memWrite),
    .memRData(memRData), .memReady(memReady)
  );

  mmuTbMem #(.Pattern(DataPattern)) memModel (
    .clk(clk), .rst(rst), .tableBase(tableBase), .memAddr(memAddr), .memWData(memWData),
    .memReq(memReq), .memWrite(memWrite), .memRData(memRData), .memReady(memReady),
    .descReads(), .dataAccesses(), .lastDataAddr()
  );

  always #2 clk = ~clk;

  task automatic compareWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic compareFault(input string name, input faultCode expected,
                              input faultCode actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic compareFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // Section descriptor built from the architectural field layout
  function automatic logic [31:0] sectionDesc(input logic [11:0] base,
                                              input logic [3:0] domain, input accessPerm ap);
    sectionDesc = {base, 8'h00, ap, 1'b0, domain, 3'b000, 2'b10};
  endfunction

  task automatic setControl(input logic [31:0] value);
    @(posedge clk);
    control <= value;
  endtask

  task automatic flushTlb;
    @(posedge clk);
    tlbFlush <= 1'b1;
    @(posedge clk);
    tlbFlush <= 1'b0;
  endtask

  // Level request held until cpuReady with outputs sampled on the falling edge
  task automatic doAccess(input logic [31:0] addr, input logic write, input logic [31:0] wdata,
                          input logic word, input logic sup, input logic data);
    @(posedge clk);
    cpuReq     <= 1'b1;
    cpuAddr    <= addr;
    cpuWrite   <= write;
    cpuWData   <= wdata;
    wordAccess <= word;
    supMode    <= sup;
    dataAccess <= data;
    do begin
      @(negedge clk);
    end while (cpuReady !== 1'b1);
    gotRData     = cpuRData;
    gotDAbort    = dataAbort;
    gotPAbort    = prefetchAbort;
    gotStatus    = faultStatus;
    gotFaultAddr = faultAddr;
    @(posedge clk);
    cpuReq <= 1'b0;
  endtask

  task automatic readSup(input logic [31:0] addr);
    doAccess(addr, 1'b0, 32'h0, 1'b1, 1'b1, 1'b1);
  endtask

  // Read with no abort and data from the expected physical address
  task automatic checkClean(input string name, input logic [31:0] physAddr);
    compareFlag({name, " dataAbort"}, 1'b0, gotDAbort);
    compareFlag({name, " prefetchAbort"}, 1'b0, gotPAbort);
    compareWord({name, " memAddr"}, physAddr, memModel.lastDataAddr);
    compareWord({name, " rdata"}, physAddr ^ DataPattern, gotRData);
  endtask

  task automatic checkAbort(input string name, input logic data, input faultCode code,
                            input logic [31:0] addr);
    compareFlag({name, " dataAbort"}, data, gotDAbort);
    compareFlag({name, " prefetchAbort"}, ~data, gotPAbort);
    compareFault({name, " status"}, code, faultCode'(gotStatus[3:0]));
    compareWord({name, " faultAddr"}, addr, gotFaultAddr);
    // Fault registers keep their value once the request drops
    @(negedge clk);
    compareFault({name, " status held"}, code, faultCode'(faultStatus[3:0]));
    compareWord({name, " faultAddr held"}, addr, faultAddr);
  endtask

  task automatic testBypass;
    setControl(32'h0);
    doAccess(32'h0800_0100, 1'b1, 32'hDEAD_BEEF, 1'b1, 1'b1, 1'b1);
    compareWord("bypass write addr", 32'h0800_0100, memModel.lastDataAddr);
    readSup(32'h0800_0100);
    compareWord("bypass readback", 32'hDEAD_BEEF, gotRData);
    readSup(32'h1234_5678);
    checkClean("bypass read", 32'h1234_5678);
  endtask

  task automatic testMissHit;
    int d0;
    setControl(32'h1);
    memModel.setDesc(12'h123, sectionDesc(12'h456, 4'd0, apFull));
    d0 = memModel.descReads;
    readSup(32'h1230_ABC4);
    compareWord("miss walk count", d0 + 1, memModel.descReads);
    checkClean("miss data", 32'h4560_ABC4);
    // Same section again hits in the TLB
    readSup(32'h123F_0010);
    compareWord("hit walk count", d0 + 1, memModel.descReads);
    checkClean("hit data", 32'h456F_0010);
  endtask

  task automatic testTranslationFault;
    int d0;
    d0 = memModel.dataAccesses;
    readSup(32'h2000_0040);
    checkAbort("translation data", 1'b1, sectionTranslationFault, 32'h2000_0040);
    doAccess(32'h2001_0000, 1'b0, 32'h0, 1'b1, 1'b1, 1'b0);
    checkAbort("translation prefetch", 1'b0, sectionTranslationFault, 32'h2001_0000);
    compareWord("translation no data access", d0, memModel.dataAccesses);
  endtask

  task automatic testDomainPerm;
    memModel.setDesc(12'h300, sectionDesc(12'h310, 4'd1, apFull));
    readSup(32'h3000_0000);
    checkAbort("domain noAccess", 1'b1, sectionDomainFault, 32'h3000_0000);
    compareWord("domain noAccess domain", 32'd1, 32'(gotStatus[7:4]));
    // User mode read of a supervisor only section
    memModel.setDesc(12'h301, sectionDesc(12'h311, 4'd3, apSupOnly));
    doAccess(32'h3010_0020, 1'b0, 32'h0, 1'b1, 1'b0, 1'b1);
    checkAbort("client supOnly", 1'b1, sectionPermissionFault, 32'h3010_0020);
    compareWord("client supOnly domain", 32'd3, 32'(gotStatus[7:4]));
    // Manager ignores the AP bits
    memModel.setDesc(12'h302, sectionDesc(12'h312, 4'd2, apSupOnly));
    doAccess(32'h3020_0020, 1'b0, 32'h0, 1'b1, 1'b0, 1'b1);
    checkClean("manager supOnly", 32'h3120_0020);
  endtask

  task automatic testAlign;
    setControl(32'h3);
    readSup(32'h7FF0_0002);
    checkAbort("align on", 1'b1, alignFault, 32'h7FF0_0002);
    // With the check off the unmapped section walks and faults
    setControl(32'h1);
    readSup(32'h7FF0_0002);
    checkAbort("align off", 1'b1, sectionTranslationFault, 32'h7FF0_0002);
  endtask

  task automatic testRefillFlush;
    logic [11:0] tags [TlbSize+1];
    logic [11:0] bases [TlbSize+1];
    logic [11:0] start;
    int          d0;
    start = 12'h400 + 12'({$random(seed)} % 256);
    for (int i = 0; i <= TlbSize; i++) begin
      tags[i]  = start + 12'(i);
      bases[i] = 12'({$random(seed)} % 1024);
      memModel.setDesc(tags[i], sectionDesc(bases[i], 4'd0, apFull));
    end
    flushTlb();
    d0 = memModel.descReads;
    for (int i = 0; i <= TlbSize; i++) begin
      readSup({tags[i], 20'h00010});
    end
    compareWord("refill fill count", d0 + TlbSize + 1, memModel.descReads);
    // Only the oldest entry was replaced
    readSup({tags[1], 20'h00020});
    compareWord("refill second kept", d0 + TlbSize + 1, memModel.descReads);
    readSup({tags[0], 20'h00030});
    compareWord("refill oldest evicted", d0 + TlbSize + 2, memModel.descReads);
    checkClean("refill oldest data", {bases[0], 20'h00030});
    flushTlb();
    d0 = memModel.descReads;
    for (int i = 0; i < TlbSize; i++) begin
      readSup({tags[i], 20'h00040});
    end
    compareWord("flush rewalk count", d0 + TlbSize, memModel.descReads);
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Watchdog expired before the directed tests finished");
    $display("tests failed");
    $fatal(1);
  end

  initial begin
    rst        = 1'b1;
    control    = 32'h0;
    tableBase  = TableBase;
    dacr       = Dacr;
    tlbFlush   = 1'b0;
    cpuReq     = 1'b0;
    cpuWrite   = 1'b0;
    wordAccess = 1'b1;
    supMode    = 1'b1;
    dataAccess = 1'b1;
    cpuAddr    = 32'h0;
    cpuWData   = 32'h0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    testBypass();
    testMissHit();
    testTranslationFault();
    testDomainPerm();
    testAlign();
    testRefillFlush();
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== list.f ====
src/mmuPkg.sv
src/memBusIf.sv
src/tlb.sv
src/tableWalker.sv
src/accessCheck.sv
src/busArbiter.sv
src/mmu.sv
verif/mmuTbMem.sv
verif/mmuTb.sv
